/* logic/z3_macros.svh */
// Zorro III card constants
`ifndef Z3_MACROS_SVH
`define Z3_MACROS_SVH
`default_nettype none

// bus data word
`define Z3_DATA_W 32
// upper address of config space
`define Z3_CFG_REGION 16'hFF00
// base tag compare width, 64 MB card
`define Z3_CARD_MATCH_BITS 6

// register index = byte offset / 4
`define Z3_REG_BASE 7'h11
`define Z3_REG_SHUTUP 7'h13

// raw nibbles: type A2, product 5A, flags 30, maker 1A2C, serial 1
`define Z3_CFG_RAW(idx) ( \
	((idx) == 7'h00) ? 4'hA : ((idx) == 7'h01) ? 4'h2 : \
	((idx) == 7'h02) ? 4'h5 : ((idx) == 7'h03) ? 4'hA : \
	((idx) == 7'h04) ? 4'h3 : ((idx) == 7'h08) ? 4'h1 : \
	((idx) == 7'h09) ? 4'hA : ((idx) == 7'h0A) ? 4'h2 : \
	((idx) == 7'h0B) ? 4'hC : ((idx) == 7'h13) ? 4'h1 : 4'h0)

// only er_Type reads true, everything else inverted
`define Z3_CFG_NIBBLE(idx) \
	(((idx) < 7'h02) ? `Z3_CFG_RAW(idx) : 4'(~`Z3_CFG_RAW(idx)))

`default_nettype wire
`endif

/* logic/zorro_pkg.sv */
// Zorro bus types
`include "z3_macros.svh"
`default_nettype none

package zorro_pkg;

	// ----------------------------------------
	// latched full-cycle address
	// ----------------------------------------

	// card space view
	typedef struct packed {
		logic [`Z3_CARD_MATCH_BITS-1:0] base;
		logic [`Z3_DATA_W-`Z3_CARD_MATCH_BITS-3:0] offset;
		logic [1:0] zero;
	} z3_card_addr_t;

	// config space view, regnum from A8..A2
	typedef struct packed {
		logic [15:0] region;
		logic [6:0] dc;
		logic [6:0] regnum;
		logic [1:0] zero;
	} z3_cfg_addr_t;

	// same word, decoded either way
	typedef union packed {
		z3_card_addr_t card;
		z3_cfg_addr_t cfg;
	} z3_addr_u;

	// data in logical order, D31..D0
	typedef logic [`Z3_DATA_W-1:0] z3_data_t;

	// ----------------------------------------
	// slave cycle states
	// ----------------------------------------
	typedef enum logic [2:0] {
		zs_idle,
		zs_match,
		zs_data,
		zs_wb_wait,
		zs_cfg_wr,
		zs_dtack
	} z3_state_e;

	// strobes in clk domain, all active high
	typedef struct packed {
		logic fcs;
		logic doe;
		logic [3:0] ds;
		logic read;
	} z3_strobe_t;

endpackage

`default_nettype wire

/* logic/wb_pkg.sv */
// Wishbone classic types
`include "z3_macros.svh"
`default_nettype none

package wb_pkg;

	// master request, held until ack
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		// word address inside the card window
		logic [`Z3_DATA_W-`Z3_CARD_MATCH_BITS-3:0] adr;
		logic [3:0] sel;
		logic [`Z3_DATA_W-1:0] dat;
	} wb_req_t;

	// slave response
	typedef struct packed {
		logic ack;
		logic [`Z3_DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

/* logic/z3_bus_sync.sv */
// Zorro strobe synchronizer
`default_nettype none

module z3_bus_sync
	import zorro_pkg::*;
(
	input wire logic clk,
	input wire logic nIORST,
	input wire logic nfcs_i,
	input wire logic doe_i,
	input wire logic read_i,
	input wire logic [3:0] nds_i,
	input wire logic [23:0] ad_i,
	input wire logic [5:0] a_i,
	input wire logic [7:0] sd_i,
	output z3_strobe_t strobe_o,
	output z3_addr_u addr_o,
	output z3_data_t wdata_o
);

	z3_strobe_t strobe_raw;
	z3_strobe_t strobe_meta;
	z3_strobe_t strobe_sync;
	z3_addr_u addr_q;

	// ----------------------------------------
	// strobes, two flops into clk
	// ----------------------------------------

	// flip the active-low bus strobes
	assign strobe_raw = '{fcs: ~nfcs_i, doe: doe_i, ds: ~nds_i, read: read_i};

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			strobe_meta <= '0;
			strobe_sync <= '0;
		end else begin
			strobe_meta <= strobe_raw;
			strobe_sync <= strobe_meta;
		end
	end

	assign strobe_o = strobe_sync;

	// ----------------------------------------
	// address latch
	// ----------------------------------------

	// master floats AD right after /FCS falls
	// A7..A2 stay valid, latched anyway
	always_ff @(negedge nfcs_i) begin
		addr_q <= {ad_i, a_i, 2'b00};
	end

	assign addr_o = addr_q;

	// bus lanes AD31..24, SD7..0, AD23..8 to D31..D0
	assign wdata_o = {ad_i[23:16], sd_i, ad_i[15:0]};

endmodule

`default_nettype wire

/* logic/z3_autoconfig.sv */
// Zorro III autoconfig
`include "z3_macros.svh"
`default_nettype none

module z3_autoconfig
	import zorro_pkg::*;
(
	input wire logic clk,
	input wire logic nIORST,
	input z3_addr_u addr_i,
	input z3_data_t wdata_i,
	input wire logic cfg_we_i,
	output logic [3:0] rdata_o,
	output logic [`Z3_CARD_MATCH_BITS-1:0] base_o,
	output logic configured_o,
	output logic ncfgout_o
);

	logic [`Z3_CARD_MATCH_BITS-1:0] base_q;
	logic configured_q;
	logic shutup_q;
	logic unconfigured;
	logic wr_base;
	logic wr_shutup;

	// ----------------------------------------
	// read side
	// ----------------------------------------

	// nibble straight from the register index
	assign rdata_o = `Z3_CFG_NIBBLE(addr_i.cfg.regnum);

	// ----------------------------------------
	// write side
	// ----------------------------------------

	// only answer writes while still in the chain
	assign unconfigured = ~configured_q & ~shutup_q;

	assign wr_base = cfg_we_i & unconfigured & (addr_i.cfg.regnum == `Z3_REG_BASE);
	assign wr_shutup = cfg_we_i & unconfigured & (addr_i.cfg.regnum == `Z3_REG_SHUTUP);

	// base tag is A31..A26 of the assigned address
	always_ff @(posedge clk) begin
		if (wr_base) begin
			base_q <= wdata_i[31:32-`Z3_CARD_MATCH_BITS];
		end
	end

	// state flags, cleared only by /IORST
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			configured_q <= 1'b0;
			shutup_q <= 1'b0;
		end else begin
			if (wr_base) begin
				configured_q <= 1'b1;
			end
			// shut up leaves the card dead on the bus
			if (wr_shutup) begin
				shutup_q <= 1'b1;
			end
		end
	end

	assign base_o = base_q;
	assign configured_o = configured_q;

	// next slot gets its turn once we are done
	assign ncfgout_o = ~(configured_q | shutup_q);

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// chain output never releases before the next reset
	a_cfgout_sticky: assert property (
		@(posedge clk) disable iff (!nIORST)
		!ncfgout_o |=> !ncfgout_o
	) else $error("ncfgout released without reset");

endmodule

`default_nettype wire

/* logic/z3_cycle_fsm.sv */
// Zorro slave cycle FSM
`default_nettype none

module z3_cycle_fsm
	import zorro_pkg::*;
	import wb_pkg::*;
(
	input wire logic clk,
	input wire logic nIORST,
	input z3_strobe_t strobe_i,
	input wire logic card_hit_i,
	input wire logic cfg_hit_i,
	input z3_addr_u addr_i,
	input z3_data_t wdata_i,
	input wire logic [3:0] cfg_rdata_i,
	input wb_rsp_t wb_rsp_i,
	output wb_req_t wb_req_o,
	output z3_data_t rdata_o,
	output logic cfg_we_o,
	output logic ndtack_o
);

	z3_state_e state_q;
	z3_state_e state_d;
	logic is_cfg_q;
	logic wb_start;
	logic wr_capture;
	logic wb_done;

	// wishbone request regs
	logic cyc_q;
	logic stb_q;
	logic we_q;
	logic [$bits(wb_req_o.adr)-1:0] adr_q;
	logic [3:0] sel_q;
	z3_data_t dat_q;
	z3_data_t rdata_q;

	assign wb_done = cyc_q & wb_rsp_i.ack;

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_d = state_q;
		wb_start = 1'b0;
		wr_capture = 1'b0;
		// master ending the cycle wins over everything
		if (!strobe_i.fcs) begin
			state_d = zs_idle;
		end else begin
			case (state_q)
				// hold off while an old transfer is still open
				zs_idle: begin
					if ((card_hit_i || cfg_hit_i) && !cyc_q) begin
						state_d = zs_match;
					end
				end
				zs_match: begin
					if (strobe_i.doe) begin
						state_d = zs_data;
					end
				end
				zs_data: begin
					if (strobe_i.read) begin
						if (is_cfg_q) begin
							state_d = zs_dtack;
						end else begin
							state_d = zs_wb_wait;
							wb_start = 1'b1;
						end
					end else if (|strobe_i.ds) begin
						// write data valid once any lane strobe is in
						wr_capture = 1'b1;
						if (is_cfg_q) begin
							state_d = zs_cfg_wr;
						end else begin
							state_d = zs_wb_wait;
							wb_start = 1'b1;
						end
					end
				end
				zs_wb_wait: begin
					if (wb_done) begin
						state_d = zs_dtack;
					end
				end
				zs_cfg_wr: state_d = zs_dtack;
				zs_dtack: state_d = zs_dtack;
				default: state_d = zs_idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			state_q <= zs_idle;
			is_cfg_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// hit kind sampled once, at cycle start
			if (state_q == zs_idle && state_d == zs_match) begin
				is_cfg_q <= cfg_hit_i;
			end
		end
	end

	// ----------------------------------------
	// wishbone master
	// ----------------------------------------

	// cyc/stb up for one transfer, down the cycle after ack
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			cyc_q <= 1'b0;
			stb_q <= 1'b0;
		end else if (wb_done) begin
			cyc_q <= 1'b0;
			stb_q <= 1'b0;
		end else if (wb_start) begin
			cyc_q <= 1'b1;
			stb_q <= 1'b1;
		end
	end

	// request payload, frozen while cyc is up
	always_ff @(posedge clk) begin
		if (wb_start) begin
			we_q <= ~strobe_i.read;
			adr_q <= addr_i.card.offset;
			sel_q <= strobe_i.ds;
		end
		if (wr_capture) begin
			dat_q <= wdata_i;
		end
	end

	assign wb_req_o = '{cyc: cyc_q, stb: stb_q, we: we_q, adr: adr_q, sel: sel_q, dat: dat_q};

	// read data, memory word or config nibble padded with ones
	always_ff @(posedge clk) begin
		if (state_q == zs_data && strobe_i.fcs && strobe_i.read && is_cfg_q) begin
			rdata_q <= {cfg_rdata_i, {($bits(z3_data_t)-4){1'b1}}};
		end else if (state_q == zs_wb_wait && wb_done && !we_q) begin
			rdata_q <= wb_rsp_i.dat;
		end
	end

	assign rdata_o = rdata_q;
	assign cfg_we_o = (state_q == zs_cfg_wr);
	assign ndtack_o = (state_q != zs_dtack);

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// request held with stb up and a steady payload until ack
	a_stb_in_cyc: assert property (
		@(posedge clk) disable iff (!nIORST)
		(wb_req_o.cyc && !wb_rsp_i.ack) |=> (wb_req_o.stb && $stable(wb_req_o))
	) else $error("wishbone request changed before ack");

	// config write only inside a selected config write cycle
	a_cfg_we_pulse: assert property (
		@(posedge clk) disable iff (!nIORST)
		cfg_we_o |-> (cfg_hit_i && !strobe_i.read)
	) else $error("cfg_we outside a config write");

endmodule

`default_nettype wire

/* logic/z3_card_top.sv */
// Zorro III memory card bus side
`include "z3_macros.svh"
`default_nettype none

module z3_card_top
	import zorro_pkg::*;
	import wb_pkg::*;
(
	input wire logic clk,
	input wire logic nIORST,
	input wire logic nFCS,
	input wire logic DOE,
	input wire logic READ,
	input wire logic [3:0] nDS,
	input wire logic [1:0] FC,
	input wire logic [7:2] A,
	input wire logic nBERR,
	input wire logic nCFGINN,
	input wb_rsp_t wb_rsp_i,
	inout wire logic [31:8] AD,
	inout wire logic [7:0] SD,
	output logic nSLAVEN,
	output logic nDTACK,
	output logic nCFGOUTN,
	output wb_req_t wb_req_o
);

	z3_strobe_t strobe;
	z3_addr_u addr;
	z3_data_t wdata;
	z3_data_t rdata;
	logic [3:0] cfg_rdata;
	logic [`Z3_CARD_MATCH_BITS-1:0] base;
	logic configured;
	logic ncfgout;
	logic cfg_we;
	logic ndtack;
	logic fc_ok;
	logic card_hit;
	logic cfg_hit;
	logic dboe;

	// ----------------------------------------
	// address and space decode
	// ----------------------------------------

	// user data or program space only
	assign fc_ok = FC[0] ^ FC[1];
	assign card_hit = (addr.card.base == base) & configured & fc_ok;
	// config space needs our turn in the chain
	assign cfg_hit = (addr.cfg.region == `Z3_CFG_REGION) & ~nCFGINN & ncfgout &
		~configured & fc_ok;

	// must answer fast, so straight from the pins
	assign nSLAVEN = nFCS | ~(card_hit | cfg_hit);

	// drivers off on any /BERR
	assign dboe = ~nSLAVEN & DOE & READ & nBERR;
	assign AD = dboe ? {rdata[31:24], rdata[15:0]} : 'z;
	assign SD = dboe ? rdata[23:16] : 'z;

	// released as soon as the master ends the cycle
	// config writes drop the hit before dtack
	assign nDTACK = nFCS | ndtack;
	assign nCFGOUTN = ncfgout;

	z3_bus_sync sync_i (
		.clk(clk),
		.nIORST(nIORST),
		.nfcs_i(nFCS),
		.doe_i(DOE),
		.read_i(READ),
		.nds_i(nDS),
		.ad_i(AD),
		.a_i(A),
		.sd_i(SD),
		.strobe_o(strobe),
		.addr_o(addr),
		.wdata_o(wdata)
	);

	z3_autoconfig acfg_i (
		.clk(clk),
		.nIORST(nIORST),
		.addr_i(addr),
		.wdata_i(wdata),
		.cfg_we_i(cfg_we),
		.rdata_o(cfg_rdata),
		.base_o(base),
		.configured_o(configured),
		.ncfgout_o(ncfgout)
	);

	z3_cycle_fsm fsm_i (
		.clk(clk),
		.nIORST(nIORST),
		.strobe_i(strobe),
		.card_hit_i(card_hit),
		.cfg_hit_i(cfg_hit),
		.addr_i(addr),
		.wdata_i(wdata),
		.cfg_rdata_i(cfg_rdata),
		.wb_rsp_i(wb_rsp_i),
		.wb_req_o(wb_req_o),
		.rdata_o(rdata),
		.cfg_we_o(cfg_we),
		.ndtack_o(ndtack)
	);

endmodule

`default_nettype wire

/* verif/tb_z3_card.sv */
// Zorro III card testbench
`include "z3_macros.svh"
`default_nettype none

module tb_z3_card
	import zorro_pkg::*;
	import wb_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] CFG_BASE = {`Z3_CFG_REGION, 16'h0000};
	localparam logic [5:0] CARD_BASE = 6'b010000;
	localparam int N_CFG = 128;
	localparam int N_WR = 48;
	localparam int N_RD = 16;
	// fixed accesses: probes, config writes, fill read
	localparam int RUN_LIMIT = (N_CFG + N_WR + N_RD + 14) * 60 + 500;
	localparam int ANSWER_LIMIT = 40;
	localparam int PROBE_CYCLES = 12;
	localparam int WAIT_DTACK = 0;
	localparam int WAIT_NONE = 2;

	logic clk;
	logic nIORST;
	logic nfcs;
	logic doe;
	logic rd;
	logic [3:0] nds;
	logic [1:0] fc;
	logic [7:2] a_lo;
	logic nberr;
	logic ncfginn;
	logic nslaven;
	logic ndtack;
	logic ncfgoutn;
	logic [31:8] ad_drv;
	logic [7:0] sd_drv;
	logic ad_oe;
	logic sd_oe;
	wire [31:8] ad_bus;
	wire [7:0] sd_bus;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp = '0;
	logic mem_busy = 1'b0;
	logic [1:0] mem_wait;
	logic [31:0] stim_seed = 32'h8507_f7ed;
	logic [31:0] delay_seed = 32'h8507_f7ed;
	z3_data_t mem [logic [23:0]];
	z3_data_t ref_mem [logic [23:0]];
	z3_data_t exp_q [$];
	z3_data_t got_q [$];
	string name_q [$];
	int checks = 0;
	int value_errs = 0;
	int missing_errs = 0;
	int other_errs = 0;
	int cycle_cnt;

	// master side of the shared lanes
	assign ad_bus = ad_oe ? ad_drv : 'z;
	assign sd_bus = sd_oe ? sd_drv : 'z;

	z3_card_top dut_i (
		.clk(clk),
		.nIORST(nIORST),
		.nFCS(nfcs),
		.DOE(doe),
		.READ(rd),
		.nDS(nds),
		.FC(fc),
		.A(a_lo),
		.nBERR(nberr),
		.nCFGINN(ncfginn),
		.wb_rsp_i(wb_rsp),
		.AD(ad_bus),
		.SD(sd_bus),
		.nSLAVEN(nslaven),
		.nDTACK(ndtack),
		.nCFGOUTN(ncfgoutn),
		.wb_req_o(wb_req)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// unwritten memory, every address bit shows up
	function automatic z3_data_t fill_word(input logic [23:0] a);
		return {~a[7:0], a};
	endfunction

	// config nibble on D31..28, rest pulled up
	function automatic z3_data_t cfg_word(input logic [6:0] idx);
		return {`Z3_CFG_NIBBLE(idx), 28'hFFF_FFFF};
	endfunction

	function automatic z3_data_t merge_word(input z3_data_t old, input z3_data_t wd,
			input logic [3:0] sel);
		z3_data_t mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old & ~mask) | (wd & mask);
	endfunction

	function automatic z3_data_t ref_word(input logic [23:0] off);
		return ref_mem.exists(off) ? ref_mem[off] : fill_word(off);
	endfunction

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic check_data(input string name, input z3_data_t exp, input z3_data_t act);
		checks++;
		if (act !== exp) begin
			value_errs++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			value_errs++;
			$display("Fail %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// pairs captured reads with their expected words
	always @(posedge clk) begin
		if (got_q.size() != 0 && exp_q.size() != 0) begin
			check_data(name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
		end
	end

	// ----------------------------------------
	// wishbone memory
	// ----------------------------------------
	always @(posedge clk) begin : mem_model
		z3_data_t word;
		if (wb_rsp.ack) begin
			wb_rsp.ack <= 1'b0;
			mem_busy <= 1'b0;
		end else if (wb_req.cyc && wb_req.stb) begin
			if (!mem_busy) begin
				// new transfer, pick its ack delay
				mem_busy <= 1'b1;
				delay_seed = lcg_step(delay_seed);
				mem_wait <= delay_seed[17:16];
			end else if (mem_wait != 0) begin
				mem_wait <= mem_wait - 2'd1;
			end else begin
				word = mem.exists(wb_req.adr) ? mem[wb_req.adr] : fill_word(wb_req.adr);
				if (wb_req.we) begin
					for (int i = 0; i < 4; i++) begin
						if (wb_req.sel[i])
							word[8*i +: 8] = wb_req.dat[8*i +: 8];
					end
					mem[wb_req.adr] = word;
				end
				wb_rsp.dat <= word;
				wb_rsp.ack <= 1'b1;
			end
		end
	end

	// ----------------------------------------
	// zorro master
	// ----------------------------------------
	task automatic apply_reset();
		@(posedge clk);
		nIORST <= 1'b0;
		repeat (3) @(posedge clk);
		nIORST <= 1'b1;
	endtask

	task automatic bus_cycle(input string name, input logic [31:0] adr, input logic [1:0] fc_v,
			input logic rd_v, input logic [3:0] sel, input z3_data_t wd, input int kind,
			output logic ok, output z3_data_t rdata);
		int n;
		int limit;
		logic slave_seen;
		// address phase, latched on /FCS fall
		@(posedge clk);
		ad_drv <= adr[31:8];
		ad_oe <= 1'b1;
		a_lo <= adr[7:2];
		fc <= fc_v;
		rd <= rd_v;
		@(posedge clk);
		nfcs <= 1'b0;
		// data phase, AD released on reads
		@(posedge clk);
		ad_drv <= {wd[31:24], wd[15:0]};
		sd_drv <= wd[23:16];
		ad_oe <= ~rd_v;
		sd_oe <= ~rd_v;
		doe <= 1'b1;
		nds <= ~sel;
		limit = (kind == WAIT_NONE) ? PROBE_CYCLES : ANSWER_LIMIT;
		ok = 1'b0;
		rdata = '0;
		slave_seen = 1'b0;
		n = 0;
		while (!ok && n < limit) begin
			@(negedge clk);
			slave_seen |= ~nslaven;
			if (kind == WAIT_DTACK)
				ok = ~ndtack;
			n++;
		end
		if (kind == WAIT_NONE) begin
			check_bit({name, " slave select seen"}, 1'b0, slave_seen);
		end else if (!ok) begin
			missing_errs++;
			$display("%s: card gave no answer within %0d cycles", name, limit);
		end else begin
			check_bit({name, " slave select seen"}, 1'b1, slave_seen);
			// lanes back to D31..D0
			rdata = {ad_bus[31:24], sd_bus, ad_bus[23:8]};
		end
		// master ends the cycle
		@(posedge clk);
		nfcs <= 1'b1;
		doe <= 1'b0;
		nds <= 4'hF;
		ad_oe <= 1'b0;
		sd_oe <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic zorro_read(input string name, input logic [31:0] adr, input z3_data_t exp);
		logic ok;
		z3_data_t rdata;
		bus_cycle(name, adr, 2'b01, 1'b1, 4'hF, '0, WAIT_DTACK, ok, rdata);
		if (ok) begin
			name_q.push_back(name);
			exp_q.push_back(exp);
			got_q.push_back(rdata);
		end
	endtask

	task automatic zorro_write(input string name, input logic [31:0] adr, input z3_data_t wd,
			input logic [3:0] sel, input int kind);
		logic ok;
		z3_data_t rdata;
		bus_cycle(name, adr, 2'b01, 1'b0, sel, wd, kind, ok, rdata);
	endtask

	task automatic expect_ignored(input string name, input logic [31:0] adr,
			input logic [1:0] fc_v);
		logic ok;
		z3_data_t rdata;
		bus_cycle(name, adr, fc_v, 1'b1, 4'hF, '0, WAIT_NONE, ok, rdata);
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin : stimulus
		z3_data_t wd;
		logic [23:0] off;
		logic [3:0] sel;
		logic [31:0] r;
		nIORST = 1'b0;
		nfcs = 1'b1;
		doe = 1'b0;
		rd = 1'b1;
		nds = 4'hF;
		fc = 2'b01;
		a_lo = '0;
		nberr = 1'b1;
		ncfginn = 1'b0;
		ad_drv = '0;
		sd_drv = '0;
		ad_oe = 1'b0;
		sd_oe = 1'b0;
		apply_reset();
		@(negedge clk);
		check_bit("reset nCFGOUTN", 1'b1, ncfgoutn);
		check_bit("reset nSLAVEN", 1'b1, nslaven);
		check_bit("reset nDTACK", 1'b1, ndtack);
		check_bit("reset wb cyc", 1'b0, wb_req.cyc);
		// whole config register window
		for (int k = 0; k < N_CFG; k++)
			zorro_read($sformatf("cfg read %02h", k), CFG_BASE | (k << 2), cfg_word(7'(k)));
		// nothing answers before configuration or in wrong spaces
		expect_ignored("card unconfigured", {CARD_BASE, 26'h10}, 2'b01);
		expect_ignored("cfg fc 00", CFG_BASE, 2'b00);
		expect_ignored("cfg fc 11", CFG_BASE, 2'b11);
		zorro_write("base write", CFG_BASE | 32'h44, {CARD_BASE, 26'h0}, 4'hF, WAIT_DTACK);
		check_bit("base write nCFGOUTN", 1'b0, ncfgoutn);
		expect_ignored("cfg after base", CFG_BASE, 2'b01);
		// 16-word pool, spread over high and low offset bits
		for (int k = 0; k < N_WR; k++) begin
			stim_seed = lcg_step(stim_seed);
			r = stim_seed;
			stim_seed = lcg_step(stim_seed);
			wd = stim_seed;
			off = {r[21:20], 19'h0, r[23:22], 1'b1};
			sel = (r[27:24] == 4'h0) ? 4'hF : r[27:24];
			zorro_write($sformatf("card write %0d", k), {CARD_BASE, off, 2'b00}, wd, sel,
				WAIT_DTACK);
			ref_mem[off] = merge_word(ref_word(off), wd, sel);
		end
		for (int k = 0; k < N_RD; k++) begin
			off = {k[1:0], 19'h0, k[3:2], 1'b1};
			zorro_read($sformatf("card read %06h", off), {CARD_BASE, off, 2'b00}, ref_word(off));
		end
		zorro_read("card read unwritten", {CARD_BASE, 24'h00_0100, 2'b00}, ref_word(24'h00_0100));
		expect_ignored("other tag", {CARD_BASE + 6'd1, 26'h0}, 2'b01);
		expect_ignored("low space", 32'h0000_1000, 2'b01);
		expect_ignored("card fc 11", {CARD_BASE, 26'h4}, 2'b11);
		// fresh card, chain closed first
		apply_reset();
		@(posedge clk);
		ncfginn <= 1'b1;
		expect_ignored("cfg chain closed", CFG_BASE, 2'b01);
		@(posedge clk);
		ncfginn <= 1'b0;
		zorro_write("shut-up write", CFG_BASE | 32'h4C, '0, 4'hF, WAIT_DTACK);
		check_bit("shut-up nCFGOUTN", 1'b0, ncfgoutn);
		expect_ignored("card after shut-up", {CARD_BASE, 26'h0}, 2'b01);
		expect_ignored("cfg after shut-up", CFG_BASE, 2'b01);
		repeat (4) @(posedge clk);
		if (got_q.size() != 0) begin
			other_errs++;
			$display("captured reads were left without a compare");
		end
		$display("checks %0d, value errors %0d, missing answers %0d, other errors %0d",
			checks, value_errs, missing_errs, other_errs);
		if (value_errs + missing_errs + other_errs == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// run limit from the number of bus cycles
	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < RUN_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("run stopped after %0d cycles before the tests finished", cycle_cnt);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+logic
logic/zorro_pkg.sv
logic/wb_pkg.sv
logic/z3_bus_sync.sv
logic/z3_autoconfig.sv
logic/z3_cycle_fsm.sv
logic/z3_card_top.sv
verif/tb_z3_card.sv

/* Bender.yml */
package:
  name: z3_card

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/zorro_pkg.sv
      - logic/wb_pkg.sv
      - logic/z3_bus_sync.sv
      - logic/z3_autoconfig.sv
      - logic/z3_cycle_fsm.sv
      - logic/z3_card_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_z3_card.sv
